//--- verilog/cache_pkg.sv
`default_nettype none

package cache_pkg;

	// address layout, 16-bit byte address
	// [15:11] tag, [10:4] line index, [3:1] word offset, bit 0 unused
	localparam int ADDR_W = 16;
	localparam int WORD_W = 16;
	localparam int TAG_W = 5;
	localparam int INDEX_W = 7;
	localparam int OFFSET_W = 3;

	// direct mapped, one way only
	localparam int LINES = 128;
	localparam int LINE_WORDS = 8;

	typedef logic [ADDR_W-1:0] addr_t;
	typedef logic [WORD_W-1:0] word_t;
	typedef logic [TAG_W-1:0] tag_t;
	typedef logic [INDEX_W-1:0] index_t;
	typedef logic [OFFSET_W-1:0] offset_t;

	// miss handling in line_fill
	// idle   passes hits, waits for a miss
	// fetch  issues the line reads
	// drain  waits for the remaining read data
	// pass   offers the filled request downstream
	typedef enum logic [1:0] {
		idle,
		fetch,
		drain,
		pass
	} fill_state_t;

endpackage

`default_nettype wire

//--- verilog/cache_stage_if.sv
`timescale 1ns/1ns
`default_nettype none

// one request moving between two pipeline stages
// valid/ready handshake, transfer when both high
interface cache_stage_if;

	logic valid;
	logic ready;
	logic write;
	cache_pkg::addr_t addr;
	cache_pkg::word_t wdata;
	// hit decision made in tag_lookup, carried to the response
	logic hit;

	// upstream side, fields held while stalled
	modport src (
		output valid,
		output write,
		output addr,
		output wdata,
		output hit,
		input ready
	);

	// downstream side only drives ready
	modport dst (
		input valid,
		input write,
		input addr,
		input wdata,
		input hit,
		output ready
	);

endinterface

`default_nettype wire

//--- verilog/line_fill_if.sv
`timescale 1ns/1ns
`default_nettype none

// fill writes from line_fill into the data array
// no handshake, data_access takes every write
interface line_fill_if;

	logic wr;
	cache_pkg::index_t index;
	cache_pkg::offset_t offset;
	cache_pkg::word_t data;

	modport src (
		output wr,
		output index,
		output offset,
		output data
	);

	modport dst (
		input wr,
		input index,
		input offset,
		input data
	);

endinterface

`default_nettype wire

//--- verilog/tag_lookup.sv
`timescale 1ns/1ns
`default_nettype none

module tag_lookup (
	input wire clk,
	input wire arst_n,
	input wire req_valid,
	input wire req_write,
	input wire cache_pkg::addr_t req_addr,
	input wire cache_pkg::word_t req_wdata,
	output logic req_ready,
	cache_stage_if.src down
);

	// request register
	logic r_valid;
	logic r_write;
	cache_pkg::addr_t r_addr;
	cache_pkg::word_t r_wdata;

	// tag store and per-line valid bits
	cache_pkg::tag_t tag_mem [cache_pkg::LINES];
	logic [cache_pkg::LINES-1:0] line_valid;

	cache_pkg::index_t idx;
	cache_pkg::tag_t tag;
	logic hit;
	logic take;
	logic load;

	// split the registered address
	assign idx = r_addr[cache_pkg::INDEX_W+cache_pkg::OFFSET_W:cache_pkg::OFFSET_W+1];
	assign tag = r_addr[cache_pkg::ADDR_W-1 -: cache_pkg::TAG_W];

	// hit needs a valid line and a matching tag
	assign hit = line_valid[idx] && (tag_mem[idx] == tag);

	// handed on this cycle
	assign take = r_valid && down.ready;

	// free slot, or the slot empties on this edge
	assign req_ready = !r_valid || take;
	assign load = req_valid && req_ready;

	// offer the held request with its hit flag in the same cycle
	assign down.valid = r_valid;
	assign down.write = r_write;
	assign down.addr = r_addr;
	assign down.wdata = r_wdata;
	assign down.hit = hit;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			r_valid <= 1'b0;
			line_valid <= '0;
		end else begin
			// a new load wins over the handoff of the old one
			if (load) begin
				r_valid <= 1'b1;
			end else if (take) begin
				r_valid <= 1'b0;
			end
			// allocate on miss handoff
			// nothing passes until the fill is done, so marking early is safe
			if (take && !hit) begin
				line_valid[idx] <= 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (load) begin
			r_write <= req_write;
			r_addr <= req_addr;
			r_wdata <= req_wdata;
		end
		// new tag goes in on the same edge as the valid bit
		if (take && !hit) begin
			tag_mem[idx] <= tag;
		end
	end

endmodule

`default_nettype wire

//--- verilog/line_fill.sv
`timescale 1ns/1ns
`default_nettype none

module line_fill (
	input wire clk,
	input wire arst_n,
	cache_stage_if.dst up,
	cache_stage_if.src down,
	output logic rd_en,
	output cache_pkg::addr_t rd_addr,
	input wire rd_valid,
	input wire cache_pkg::word_t rd_data,
	line_fill_if.src fill
);

	cache_pkg::fill_state_t state;

	// missed request, held through the fill
	logic h_write;
	cache_pkg::addr_t h_addr;
	cache_pkg::word_t h_wdata;

	// word offsets issued and returned
	cache_pkg::offset_t iss_cnt;
	cache_pkg::offset_t rcv_cnt;

	logic idle_st;
	logic busy;
	logic miss_in;
	logic last_iss;
	logic last_rcv;

	assign idle_st = (state == cache_pkg::idle);
	// reads outstanding in fetch and drain
	assign busy = (state == cache_pkg::fetch) || (state == cache_pkg::drain);
	assign miss_in = idle_st && up.valid && !up.hit;
	assign last_iss = (iss_cnt == cache_pkg::offset_t'(cache_pkg::LINE_WORDS - 1));
	assign last_rcv = (rcv_cnt == cache_pkg::offset_t'(cache_pkg::LINE_WORDS - 1));

	// hits flow through with downstream ready
	// a miss is taken in idle, then ready stays low until back in idle
	assign up.ready = idle_st && (!up.hit || down.ready);

	// idle forwards hits combinationally, pass offers the filled miss
	assign down.valid = idle_st ? (up.valid && up.hit) : (state == cache_pkg::pass);
	assign down.write = idle_st ? up.write : h_write;
	assign down.addr = idle_st ? up.addr : h_addr;
	assign down.wdata = idle_st ? up.wdata : h_wdata;
	// filled request goes on as a miss
	assign down.hit = idle_st && up.hit;

	// one read per cycle, line base plus issue offset
	assign rd_en = (state == cache_pkg::fetch);
	assign rd_addr = {h_addr[cache_pkg::ADDR_W-1:cache_pkg::OFFSET_W+1], iss_cnt, 1'b0};

	// returned words go straight into the data array, in order
	assign fill.wr = busy && rd_valid;
	assign fill.index = h_addr[cache_pkg::INDEX_W+cache_pkg::OFFSET_W:cache_pkg::OFFSET_W+1];
	assign fill.offset = rcv_cnt;
	assign fill.data = rd_data;

	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			state <= cache_pkg::idle;
			iss_cnt <= '0;
			rcv_cnt <= '0;
		end else begin
			case (state)
				cache_pkg::idle: begin
					if (miss_in) begin
						state <= cache_pkg::fetch;
						iss_cnt <= '0;
						rcv_cnt <= '0;
					end
				end
				cache_pkg::fetch: begin
					iss_cnt <= iss_cnt + 1'b1;
					if (last_iss) begin
						state <= cache_pkg::drain;
					end
				end
				cache_pkg::drain: begin
					// latency of one or more puts the last word here
					if (rd_valid && last_rcv) begin
						state <= cache_pkg::pass;
					end
				end
				cache_pkg::pass: begin
					if (down.ready) begin
						state <= cache_pkg::idle;
					end
				end
				default: begin
					state <= cache_pkg::idle;
				end
			endcase
			// count returns in fetch as well as drain
			if (fill.wr) begin
				rcv_cnt <= rcv_cnt + 1'b1;
			end
		end
	end

	// capture the miss when it is accepted
	always_ff @(posedge clk) begin
		if (miss_in) begin
			h_write <= up.write;
			h_addr <= up.addr;
			h_wdata <= up.wdata;
		end
	end

endmodule

`default_nettype wire

//--- verilog/data_access.sv
`timescale 1ns/1ns
`default_nettype none

module data_access (
	input wire clk,
	input wire arst_n,
	cache_stage_if.dst up,
	line_fill_if.dst fill,
	output logic wr_en,
	output cache_pkg::addr_t wr_addr,
	output cache_pkg::word_t wr_data,
	output logic resp_valid,
	output logic resp_hit,
	output logic resp_write,
	output cache_pkg::word_t resp_rdata
);

	localparam int ARRAY_WORDS = cache_pkg::LINES * cache_pkg::LINE_WORDS;

	// 128 lines x 8 words
	cache_pkg::word_t data_mem [ARRAY_WORDS];

	// word index into the array, address bits 10 to 1
	logic [cache_pkg::INDEX_W+cache_pkg::OFFSET_W-1:0] req_word;
	logic accept;

	// never stalls
	assign up.ready = 1'b1;
	assign accept = up.valid && up.ready;

	assign req_word = up.addr[cache_pkg::INDEX_W+cache_pkg::OFFSET_W:1];

	// write-through, memory takes the store on the accept edge
	assign wr_en = accept && up.write;
	assign wr_addr = up.addr;
	assign wr_data = up.wdata;

	// fill writes and request writes never share a cycle
	// line_fill only forwards once its last fill word is written
	always_ff @(posedge clk) begin
		if (fill.wr) begin
			data_mem[{fill.index, fill.offset}] <= fill.data;
		end
		if (accept && up.write) begin
			data_mem[req_word] <= up.wdata;
		end
	end

	// response fields
	// a store echoes its own word
	always_ff @(posedge clk) begin
		if (accept) begin
			resp_rdata <= up.write ? up.wdata : data_mem[req_word];
			resp_hit <= up.hit;
			resp_write <= up.write;
		end
	end

	// one-cycle pulse after each accept
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			resp_valid <= 1'b0;
		end else begin
			resp_valid <= accept;
		end
	end

endmodule

`default_nettype wire

//--- verilog/backing_memory.sv
`timescale 1ns/1ns
`default_nettype none

module backing_memory #(
	parameter int MEM_LATENCY = 4
) (
	input wire clk,
	input wire arst_n,
	input wire rd_en,
	input wire cache_pkg::addr_t rd_addr,
	output logic rd_valid,
	output cache_pkg::word_t rd_data,
	input wire wr_en,
	input wire cache_pkg::addr_t wr_addr,
	input wire cache_pkg::word_t wr_data
);

	// word addressed, bit 0 of the byte address dropped
	localparam int MEM_WORDS = 2 ** (cache_pkg::ADDR_W - 1);

	cache_pkg::word_t mem [MEM_WORDS];

	// read pipeline, entry 0 loads on the issue edge
	logic [MEM_LATENCY-1:0] v_pipe;
	cache_pkg::word_t d_pipe [MEM_LATENCY];

	logic [cache_pkg::ADDR_W-2:0] rd_word;
	logic [cache_pkg::ADDR_W-2:0] wr_word;
	cache_pkg::word_t rd_word_data;

	assign rd_word = rd_addr[cache_pkg::ADDR_W-1:1];
	assign wr_word = wr_addr[cache_pkg::ADDR_W-1:1];

	// a write on the same edge is seen by the read
	assign rd_word_data = (wr_en && (wr_word == rd_word)) ? wr_data : mem[rd_word];

	// memory model starts out all zero
	initial begin
		for (int i = 0; i < MEM_WORDS; i++) begin
			mem[i] = '0;
		end
	end

	always @(posedge clk) begin
		if (wr_en) begin
			mem[wr_word] <= wr_data;
		end
	end

	// valid bits shift along with the data
	always_ff @(posedge clk or negedge arst_n) begin
		if (!arst_n) begin
			v_pipe <= '0;
		end else begin
			v_pipe[0] <= rd_en;
			for (int i = 1; i < MEM_LATENCY; i++) begin
				v_pipe[i] <= v_pipe[i-1];
			end
		end
	end

	always_ff @(posedge clk) begin
		d_pipe[0] <= rd_word_data;
		for (int i = 1; i < MEM_LATENCY; i++) begin
			d_pipe[i] <= d_pipe[i-1];
		end
	end

	// last entry is MEM_LATENCY cycles after issue
	assign rd_valid = v_pipe[MEM_LATENCY-1];
	assign rd_data = d_pipe[MEM_LATENCY-1];

endmodule

`default_nettype wire

//--- verilog/cache_top.sv
`timescale 1ns/1ns
`default_nettype none

module cache_top #(
	parameter int MEM_LATENCY = 4
) (
	input wire clk,
	input wire arst_n,
	input wire req_valid,
	output logic req_ready,
	input wire req_write,
	input wire cache_pkg::addr_t req_addr,
	input wire cache_pkg::word_t req_wdata,
	output logic resp_valid,
	output cache_pkg::word_t resp_rdata,
	output logic resp_hit,
	output logic resp_write
);

	// memory read port, line_fill side
	logic rd_en;
	cache_pkg::addr_t rd_addr;
	logic rd_valid;
	cache_pkg::word_t rd_data;

	// memory write port, data_access side
	logic wr_en;
	cache_pkg::addr_t wr_addr;
	cache_pkg::word_t wr_data;

	// tag_lookup to line_fill, line_fill to data_access
	cache_stage_if lookup_to_fill ();
	cache_stage_if fill_to_access ();
	line_fill_if fill_wr ();

	tag_lookup u_tag_lookup (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.req_ready(req_ready),
		.down(lookup_to_fill.src)
	);

	line_fill u_line_fill (
		.clk(clk),
		.arst_n(arst_n),
		.up(lookup_to_fill.dst),
		.down(fill_to_access.src),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.fill(fill_wr.src)
	);

	data_access u_data_access (
		.clk(clk),
		.arst_n(arst_n),
		.up(fill_to_access.dst),
		.fill(fill_wr.dst),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data),
		.resp_valid(resp_valid),
		.resp_hit(resp_hit),
		.resp_write(resp_write),
		.resp_rdata(resp_rdata)
	);

	backing_memory #(
		.MEM_LATENCY(MEM_LATENCY)
	) u_backing_memory (
		.clk(clk),
		.arst_n(arst_n),
		.rd_en(rd_en),
		.rd_addr(rd_addr),
		.rd_valid(rd_valid),
		.rd_data(rd_data),
		.wr_en(wr_en),
		.wr_addr(wr_addr),
		.wr_data(wr_data)
	);

endmodule

`default_nettype wire

//--- tests/cache_checker.sv
`timescale 1ns/1ns
`default_nettype none

module cache_checker (
	input wire clk,
	input wire req_ready,
	input wire resp_valid,
	input wire cache_pkg::word_t resp_rdata,
	input wire resp_hit,
	input wire resp_write
);

	// expected responses in request order
	string name_q[$];
	cache_pkg::word_t data_q[$];
	logic hit_q[$];
	logic write_q[$];

	int mismatch_count = 0;
	int other_count = 0;

	task automatic expect_resp(input string name, input cache_pkg::word_t data,
			input logic hit, input logic write);
		name_q.push_back(name);
		data_q.push_back(data);
		hit_q.push_back(hit);
		write_q.push_back(write);
	endtask

	function automatic int pending();
		return name_q.size();
	endfunction

	task automatic report_failure(input string msg);
		$display("%s", msg);
		other_count++;
	endtask

	task automatic compare(input string name, input string field,
			input logic [15:0] expected, input logic [15:0] actual);
		if (expected !== actual) begin
			$display("mismatch %s %s: expected %h, actual %h", name, field, expected, actual);
			mismatch_count++;
		end
	endtask

	task automatic drop_front();
		void'(name_q.pop_front());
		void'(data_q.pop_front());
		void'(hit_q.pop_front());
		void'(write_q.pop_front());
	endtask

	// response registers are stable on the falling edge
	always @(negedge clk) begin
		if (resp_valid) begin
			if (name_q.size() == 0) begin
				report_failure("a response arrived while no request was waiting for one");
			end else begin
				compare(name_q[0], "rdata", data_q[0], resp_rdata);
				compare(name_q[0], "hit", {15'd0, hit_q[0]}, {15'd0, resp_hit});
				compare(name_q[0], "write", {15'd0, write_q[0]}, {15'd0, resp_write});
				drop_front();
			end
		end
	end

	// idle outputs once reset is released
	task automatic check_after_reset(input string name);
		compare(name, "req_ready", 16'd1, {15'd0, req_ready});
		compare(name, "resp_valid", 16'd0, {15'd0, resp_valid});
	endtask

	// every request still waiting got no response
	task automatic report_leftovers();
		while (name_q.size() > 0) begin
			report_failure($sformatf("no response was seen for %s", name_q[0]));
			drop_front();
		end
	endtask

endmodule

`default_nettype wire

//--- tests/cache_tb.sv
`timescale 1ns/1ns
`default_nettype none

module cache_tb;

	localparam int PERIOD = 8;
	localparam int MEM_LATENCY = 4;
	localparam int RESET_CYCLES = 2;
	localparam int MAX_VEC = 64;
	// longest gap plus fill plus response for one request
	localparam int DRAIN_CYCLES = 2 * (16 + MEM_LATENCY);
	// line index 0 is never touched by the vectors
	localparam cache_pkg::addr_t SPARE_ADDR = 16'h0000;

	logic clk;
	logic arst_n;
	logic req_valid;
	logic req_ready;
	logic req_write;
	cache_pkg::addr_t req_addr;
	cache_pkg::word_t req_wdata;
	logic resp_valid;
	cache_pkg::word_t resp_rdata;
	logic resp_hit;
	logic resp_write;

	// each vector takes four words in op address data hit order
	logic [15:0] vec_mem [4*MAX_VEC];
	int vec_count;
	logic loaded;
	logic [15:0] lfsr_state;
	int gap;

	cache_top #(
		.MEM_LATENCY(MEM_LATENCY)
	) uut (
		.clk(clk),
		.arst_n(arst_n),
		.req_valid(req_valid),
		.req_ready(req_ready),
		.req_write(req_write),
		.req_addr(req_addr),
		.req_wdata(req_wdata),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_hit(resp_hit),
		.resp_write(resp_write)
	);

	cache_checker checks (
		.clk(clk),
		.req_ready(req_ready),
		.resp_valid(resp_valid),
		.resp_rdata(resp_rdata),
		.resp_hit(resp_hit),
		.resp_write(resp_write)
	);

	initial begin
		clk = 1'b0;
		forever #(PERIOD / 2) clk = ~clk;
	end

	// x^16 + x^14 + x^13 + x^11
	function automatic logic [15:0] lfsr_next(input logic [15:0] s);
		return {s[14:0], s[15] ^ s[13] ^ s[12] ^ s[10]};
	endfunction

	// 0 to 3 idle cycles with one lfsr step per bit
	task automatic random_gap(output int n);
		n = 0;
		repeat (2) begin
			lfsr_state = lfsr_next(lfsr_state);
			n = (n << 1) | int'(lfsr_state[0]);
		end
	endtask

	// list ends at the first op of f
	function automatic int count_vectors();
		int n;
		n = 0;
		while (n < MAX_VEC && vec_mem[4*n] != 16'hf) begin
			n++;
		end
		return n;
	endfunction

	task automatic apply_reset();
		arst_n = 1'b0;
		repeat (RESET_CYCLES) @(negedge clk);
		arst_n = 1'b1;
	endtask

	// starts on a falling edge and returns on the one after the transfer
	// an untracked request is one that a reset is meant to drop
	task automatic send_request(input logic wr, input cache_pkg::addr_t addr,
			input cache_pkg::word_t data, input string name, input logic exp_hit,
			input logic tracked);
		logic accepted;
		accepted = 1'b0;
		req_valid = 1'b1;
		req_write = wr;
		req_addr = addr;
		req_wdata = wr ? data : '0;
		while (!accepted) begin
			// ready depends on registers only and holds until the rising edge
			if (req_ready) begin
				accepted = 1'b1;
				// a write echoes its own word
				if (tracked) begin
					checks.expect_resp(name, data, exp_hit, wr);
				end
			end
			@(negedge clk);
		end
		req_valid = 1'b0;
	endtask

	task automatic run_vector(input int i);
		send_request(vec_mem[4*i][0], vec_mem[4*i+1], vec_mem[4*i+2],
			$sformatf("vec%0d", i), vec_mem[4*i+3][0], 1'b1);
	endtask

	task automatic wait_drained();
		int waited;
		waited = 0;
		// the checker pops on falling edges and the queue is polled on rising ones
		while (checks.pending() != 0 && waited < DRAIN_CYCLES) begin
			@(posedge clk);
			waited++;
		end
		checks.report_leftovers();
		@(negedge clk);
	endtask

	task automatic print_counts();
		$display("errors: %0d mismatches, %0d other failures",
			checks.mismatch_count, checks.other_count);
	endtask

	initial begin
		arst_n = 1'b0;
		req_valid = 1'b0;
		req_write = 1'b0;
		req_addr = '0;
		req_wdata = '0;
		lfsr_state = 16'd64;
		loaded = 1'b0;
		$readmemh("tests/cache_vectors.txt", vec_mem);
		vec_count = count_vectors();
		loaded = 1'b1;
		if (vec_count == 0) begin
			checks.report_failure("no vectors were read from tests/cache_vectors.txt");
		end
		apply_reset();
		for (int i = 0; i < vec_count; i++) begin
			run_vector(i);
			random_gap(gap);
			repeat (gap) @(negedge clk);
		end
		wait_drained();
		// a miss starts its fill and a second read waits behind it
		send_request(1'b0, SPARE_ADDR, '0, "dropped miss", 1'b0, 1'b0);
		send_request(1'b0, SPARE_ADDR + 16'd2, '0, "dropped wait", 1'b0, 1'b0);
		// reset in the middle of the fill drops both and frees the request slot
		apply_reset();
		checks.check_after_reset("second reset");
		if (vec_count > 0) begin
			// the first vector's line was valid before the reset and now misses
			send_request(1'b0, vec_mem[1], vec_mem[2], "replay vec0", 1'b0, 1'b1);
		end
		wait_drained();
		print_counts();
		if (checks.mismatch_count + checks.other_count == 0) begin
			$display("Simulation completed successfully");
		end else begin
			$display("Simulation failed");
		end
		$finish;
	end

	// limit grows with the vector count plus the three extra requests
	initial begin
		longint limit;
		wait (loaded);
		limit = longint'(vec_count + 3) * (8 + MEM_LATENCY + 8) * PERIOD
			+ 2 * RESET_CYCLES * PERIOD;
		#(limit);
		$display("timeout: run did not finish within %0d ns", limit);
		print_counts();
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- tests/cache_vectors.txt
// op addr data hit, all hex; op 0 read, 1 write, f ends the list
// data is the expected read word, or the written word that a write echoes
1 0120 1111 0
0 0120 1111 1
0 0200 0000 0
0 0202 0000 1
0 020e 0000 1
1 0204 beef 1
0 0204 beef 1
0 0a04 0000 0
0 0204 beef 0
0 0206 0000 1
1 0206 0042 1
0 0206 0042 1
1 0340 1234 0
0 0342 0000 1
0 0340 1234 1
1 1500 a5a5 0
0 1d00 0000 0
0 1500 a5a5 0
1 1d02 5a5a 0
0 1500 a5a5 0
0 1d02 5a5a 0
0 f7fe 0000 0
1 f7fe c0de 1
0 f7f0 0000 1
0 f7fe c0de 1
0 0122 0000 1
f 0000 0000 0

//--- sources.f
verilog/cache_pkg.sv
verilog/cache_stage_if.sv
verilog/line_fill_if.sv
verilog/tag_lookup.sv
verilog/line_fill.sv
verilog/data_access.sv
verilog/backing_memory.sv
verilog/cache_top.sv
tests/cache_checker.sv
tests/cache_tb.sv

//--- Makefile
TOP = cache_tb

all:
	verilator --binary --timing --top-module $(TOP) -f sources.f
	@out=$$(./obj_dir/V$(TOP)); \
	echo "$$out"; \
	echo "$$out" | grep -q "Simulation completed successfully"

lint:
	verilator --lint-only --timing -Wall --top-module $(TOP) -f sources.f

clean:
	rm -rf obj_dir

.PHONY: all lint clean
